//--- flist.f
logic/fm_timing_pkg.sv
logic/fm_data_pkg.sv
logic/slot_sequencer.sv
logic/fm_operator.sv
logic/modulation_matrix.sv
logic/voice_mixer.sv
logic/fm_voice_core.sv
sim/tb_fm_voice_core.sv

//--- Makefile
TOP = tb_fm_voice_core

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module fm_voice_core -f flist.f

clean:
	rm -rf obj_dir

//--- sim/tb_fm_voice_core.sv
`default_nettype none

module tb_fm_voice_core;

    timeunit 1ns;
    timeprecision 1ps;

    import fm_timing_pkg::*;
    import fm_data_pkg::*;

    // 5 tests of ~64 writes and up to 10 frames of 16 slots, plus pauses and drain
    localparam int MAX_CYCLES = 4000;
    localparam logic [31:0] SEED = 32'h4dac3497;
    localparam real TWO_PI = 6.283185307179586;

    logic       sCLK_XVXENVS;
    logic       reset;
    logic       enable;
    cfg_write_t cfg;
    voice_out_t voice_out;

    int          cycles = 0;
    logic [31:0] rng_state;
    int          slot_pos;      // slot the next enabled cycle issues
    int          sat_hits;      // saturations seen by the model
    int          sine_ref [256];

    logic [15:0] m_phase   [NUM_VOICES][NUM_OSCS];
    logic [15:0] m_inc     [NUM_VOICES][NUM_OSCS];
    int          m_level   [NUM_VOICES][NUM_OSCS];
    int          m_mod     [NUM_VOICES][NUM_OSCS];
    bit          m_carrier [NUM_VOICES][NUM_OSCS];
    int          m_coef    [NUM_OSCS][NUM_OSCS];   // [target][source]

    voice_out_t exp_q[$];
    voice_out_t got_q[$];
    int         exp_stamp_q[$];
    int         got_stamp_q[$];

    fm_voice_core uut (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .enable       (enable),
        .cfg          (cfg),
        .voice_out    (voice_out)
    );

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #5 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge sCLK_XVXENVS) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // outputs are stable mid-cycle
    always @(negedge sCLK_XVXENVS) begin
        if (voice_out.valid === 1'b1) begin
            got_q.push_back(voice_out);
            got_stamp_q.push_back(cycles);
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int round_real(real x);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(0.5 - x);
    endfunction

    task automatic check_voice_out(voice_out_t got, voice_out_t exp);
        if (got !== exp) begin
            fail_run($sformatf({"Mismatch at %0t: voice_out got {voice %0d, sum %0d}",
                                " expected {voice %0d, sum %0d}"}, $time, got.voice,
                               $signed(got.sum), exp.voice, $signed(exp.sum)));
        end
    endtask

    task automatic check_pulse_count(string window, int got, int exp);
        if (got != exp) begin
            fail_run($sformatf("Mismatch at %0t: voice_out.valid pulses (%s) got %0d expected %0d",
                               $time, window, got, exp));
        end
    endtask

    task automatic check_latency(int got, int exp);
        if (got != exp) begin
            fail_run($sformatf("Mismatch at %0t: voice_out.valid cycle got %0d expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic reset_dut();
        @(negedge sCLK_XVXENVS);
        reset  = 1'b1;
        enable = 1'b0;
        cfg    = '0;
        repeat (3) @(negedge sCLK_XVXENVS);
        reset = 1'b0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            for (int o = 0; o < NUM_OSCS; o++) begin
                m_phase[v][o]   = '0;
                m_inc[v][o]     = '0;
                m_level[v][o]   = 0;
                m_mod[v][o]     = 0;
                m_carrier[v][o] = 1'b0;
            end
        end
        for (int t = 0; t < NUM_OSCS; t++) begin
            for (int o = 0; o < NUM_OSCS; o++) begin
                m_coef[t][o] = 0;
            end
        end
        sat_hits = 0;
        slot_pos = 0;
        exp_q.delete();
        got_q.delete();
        exp_stamp_q.delete();
        got_stamp_q.delete();
    endtask

    task automatic write_cfg(cfg_kind_t kind_sel, int v, int o, int t, logic [15:0] data);
        @(negedge sCLK_XVXENVS);
        cfg = '{we: 1'b1, kind: kind_sel, voice: voice_idx_t'(v), osc: osc_idx_t'(o),
                target: osc_idx_t'(t), data: data};
        case (kind_sel)
            CFG_INC:     m_inc[v][o]     = data;
            CFG_LEVEL:   m_level[v][o]   = int'(data[7:0]);
            CFG_CARRIER: m_carrier[v][o] = data[0];
            default:     m_coef[t][o]    = int'($signed(data[7:0]));
        endcase
    endtask

    task automatic randomize_config();
        logic [31:0] r;
        for (int v = 0; v < NUM_VOICES; v++) begin
            for (int o = 0; o < NUM_OSCS; o++) begin
                r = xorshift();
                write_cfg(CFG_INC, v, o, 0, r[15:0]);
                write_cfg(CFG_LEVEL, v, o, 0, {8'h00, r[23:16]});
                write_cfg(CFG_CARRIER, v, o, 0, 16'((o == 0) || r[24])); // op 0 always sounds
            end
        end
        for (int t = 0; t < NUM_OSCS; t++) begin
            for (int o = 0; o < NUM_OSCS; o++) begin
                r = xorshift();
                write_cfg(CFG_COEF, 0, o, t, {8'h00, r[7:0]});
            end
        end
    endtask

    // expected voice_out sequence for the next frames
    task automatic model_frames(int frames);
        logic [15:0] p;
        int          samp [NUM_OSCS];
        int          sum;
        int          acc;
        for (int f = 0; f < frames; f++) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                for (int o = 0; o < NUM_OSCS; o++) begin
                    p = m_phase[v][o] + 16'(m_mod[v][o] * MOD_PHASE_SCALE);
                    samp[o] = (sine_ref[p[15:8]] * m_level[v][o]) >>> 8;
                    m_phase[v][o] = m_phase[v][o] + m_inc[v][o];
                end
                sum = 0;
                for (int o = 0; o < NUM_OSCS; o++) begin
                    if (m_carrier[v][o]) sum += samp[o];
                end
                for (int t = 0; t < NUM_OSCS; t++) begin
                    acc = 0;
                    for (int o = 0; o < NUM_OSCS; o++) begin
                        acc += m_coef[t][o] * samp[o];
                    end
                    acc = acc >>> MOD_SHIFT;
                    if (acc > 2047 || acc < -2047) begin
                        sat_hits++;
                        acc = (acc > 0) ? 2047 : -2047;
                    end
                    m_mod[v][t] = acc;              // used in the next frame
                end
                exp_q.push_back('{valid: 1'b1, voice: voice_idx_t'(v),
                                  sum: voice_sample_t'(sum)});
            end
        end
    endtask

    task automatic run_frames(int frames, bit pauses);
        int gap;
        for (int s = 0; s < frames * NUM_SLOTS; s++) begin
            if (pauses && (xorshift() % 6 == 0)) begin
                gap = 1 + int'(xorshift() % 5);
                repeat (gap) begin
                    @(negedge sCLK_XVXENVS);
                    cfg.we = 1'b0;
                    enable = 1'b0;
                end
            end
            @(negedge sCLK_XVXENVS);
            cfg.we = 1'b0;
            enable = 1'b1;
            if (slot_pos % NUM_OSCS == NUM_OSCS - 1) begin
                exp_stamp_q.push_back(cycles + 4); // tag at next edge, voice_out 3 later
            end
            slot_pos = (slot_pos + 1) % NUM_SLOTS;
        end
        @(negedge sCLK_XVXENVS);
        enable = 1'b0;
    endtask

    task automatic collect_and_compare(string window);
        int guard;
        guard = 0;
        while (got_q.size() < exp_q.size() && guard < 20) begin
            @(posedge sCLK_XVXENVS);
            guard++;
        end
        repeat (4) @(posedge sCLK_XVXENVS);  // catch extra pulses
        check_pulse_count(window, got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_voice_out(got_q[i], exp_q[i]);
            check_latency(got_stamp_q[i], exp_stamp_q[i]);
        end
        exp_q.delete();
        got_q.delete();
        exp_stamp_q.delete();
        got_stamp_q.delete();
    endtask

    task automatic test_idle_after_reset();
        reset_dut();
        model_frames(4);
        run_frames(4, 1'b0);
        collect_and_compare("four frames at zero level");
        repeat (30) @(posedge sCLK_XVXENVS);
        check_pulse_count("enable low", got_q.size(), 0);
    endtask

    task automatic test_pure_tone();
        logic [31:0] r;
        reset_dut();
        for (int v = 0; v < NUM_VOICES; v++) begin
            r = xorshift();
            write_cfg(CFG_INC, v, 0, 0, r[15:0]);
            write_cfg(CFG_LEVEL, v, 0, 0, 16'(1 + r[23:16] % 255));
            write_cfg(CFG_CARRIER, v, 0, 0, 16'd1);
        end
        model_frames(10);
        run_frames(10, 1'b0);
        collect_and_compare("pure tone");
    endtask

    task automatic test_modulation_routing();
        logic [31:0] r;
        reset_dut();
        for (int v = 0; v < NUM_VOICES; v++) begin
            r = xorshift();
            write_cfg(CFG_INC, v, 0, 0, r[15:0]);
            write_cfg(CFG_INC, v, 1, 0, r[31:16]);
            r = xorshift();
            write_cfg(CFG_LEVEL, v, 0, 0, 16'(1 + r[7:0] % 255));
            write_cfg(CFG_LEVEL, v, 1, 0, 16'(1 + r[15:8] % 255));
            write_cfg(CFG_CARRIER, v, 0, 0, 16'd1);  // op 1 only modulates
        end
        write_cfg(CFG_COEF, 0, 1, 0, 16'(20 + xorshift() % 100));
        model_frames(8);
        run_frames(8, 1'b0);
        collect_and_compare("op 1 into op 0");

        // three full-level sources at the largest weight
        reset_dut();
        for (int v = 0; v < NUM_VOICES; v++) begin
            write_cfg(CFG_INC, v, 0, 0, xorshift() & 32'hffff);
            write_cfg(CFG_LEVEL, v, 0, 0, 16'd200);
            write_cfg(CFG_CARRIER, v, 0, 0, 16'd1);
            for (int o = 1; o < NUM_OSCS; o++) begin
                write_cfg(CFG_INC, v, o, 0, 16'h0800 + 16'(v * 256));
                write_cfg(CFG_LEVEL, v, o, 0, 16'd255);
            end
        end
        for (int o = 1; o < NUM_OSCS; o++) begin
            write_cfg(CFG_COEF, 0, o, 0, 16'd127);
        end
        model_frames(8);
        if (sat_hits == 0) begin
            fail_run("Saturating modulation case was not reached by the stimulus");
        end
        run_frames(8, 1'b0);
        collect_and_compare("saturating modulation");
    endtask

    task automatic test_random_all();
        reset_dut();
        randomize_config();
        model_frames(8);
        run_frames(8, 1'b0);
        collect_and_compare("random configuration");
    endtask

    task automatic test_pause();
        reset_dut();
        randomize_config();
        model_frames(10);
        run_frames(10, 1'b1);
        collect_and_compare("paused run");
    endtask

    initial begin
        reset     = 1'b1;
        enable    = 1'b0;
        cfg       = '0;
        rng_state = SEED;
        for (int k = 0; k < 256; k++) begin
            sine_ref[k] = round_real(real'(SINE_AMPL) * $sin(TWO_PI * real'(k) / 256.0));
        end
        test_idle_after_reset();
        test_pure_tone();
        test_modulation_routing();
        test_random_all();
        test_pause();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fm_voice_core.sv
`default_nettype none

module fm_voice_core (
    input  wire                        sCLK_XVXENVS,
    input  wire                        reset,
    input  logic                       enable,
    input  fm_data_pkg::cfg_write_t    cfg,
    output fm_data_pkg::voice_out_t    voice_out
);

    import fm_timing_pkg::*;
    import fm_data_pkg::*;

    slot_tag_t  tag;
    slot_tag_t  mod_query;
    mod_t       mod_value;
    op_sample_t op_out;

    slot_sequencer u_sequencer (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .enable       (enable),
        .tag          (tag)
    );

    fm_operator u_operator (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg          (cfg),
        .tag          (tag),
        .mod_query    (mod_query),
        .mod_value    (mod_value),
        .op_out       (op_out)
    );

    // modulation read back in the same cycle as the query
    modulation_matrix u_matrix (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg          (cfg),
        .op_in        (op_out),
        .mod_query    (mod_query),
        .mod_value    (mod_value)
    );

    voice_mixer u_mixer (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg          (cfg),
        .op_in        (op_out),
        .voice_out    (voice_out)
    );

endmodule

`default_nettype wire

//--- logic/voice_mixer.sv
`default_nettype none

module voice_mixer (
    input  wire                        sCLK_XVXENVS,
    input  wire                        reset,
    input  fm_data_pkg::cfg_write_t    cfg,
    input  fm_data_pkg::op_sample_t    op_in,
    output fm_data_pkg::voice_out_t    voice_out
);

    import fm_timing_pkg::*;
    import fm_data_pkg::*;

    logic          carrier [NUM_VOICES][NUM_OSCS];
    voice_sample_t run_sum;     // current voice
    voice_sample_t sum_next;

    always_comb begin
        sum_next = run_sum;
        if (carrier[op_in.tag.voice][op_in.tag.osc]) begin
            sum_next = run_sum + voice_sample_t'(op_in.sample);
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            run_sum   <= '0;
            voice_out <= '0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                for (int o = 0; o < NUM_OSCS; o++) begin
                    carrier[v][o] <= 1'b0;
                end
            end
        end else begin
            voice_out.valid <= 1'b0;             // one-cycle pulse
            if (op_in.tag.valid) begin
                if (op_in.tag.last_osc) begin
                    voice_out <= '{valid: 1'b1, voice: op_in.tag.voice, sum: sum_next};
                    run_sum   <= '0;
                end else begin
                    run_sum <= sum_next;
                end
            end
            if (cfg.we && cfg.kind == CFG_CARRIER) begin
                carrier[cfg.voice][cfg.osc] <= cfg.data[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/modulation_matrix.sv
`default_nettype none

module modulation_matrix (
    input  wire                        sCLK_XVXENVS,
    input  wire                        reset,
    input  fm_data_pkg::cfg_write_t    cfg,
    input  fm_data_pkg::op_sample_t    op_in,
    input  fm_timing_pkg::slot_tag_t   mod_query,
    output fm_data_pkg::mod_t          mod_value
);

    import fm_timing_pkg::*;
    import fm_data_pkg::*;

    coef_t coef      [NUM_OSCS][NUM_OSCS];   // [target][source], all voices
    logic signed [23:0] acc      [NUM_OSCS]; // voice in flight
    logic signed [23:0] acc_next [NUM_OSCS];
    mod_t  mod_store [NUM_VOICES][NUM_OSCS];

    function automatic mod_t saturate(logic signed [23:0] value);
        logic signed [23:0] shifted;
        logic signed [23:0] limit;
        shifted = value >>> MOD_SHIFT;
        limit   = (24'sd1 <<< ($bits(mod_t) - 1)) - 24'sd1;
        if (shifted > limit) begin
            return mod_t'(limit);
        end else if (shifted < -limit) begin
            return mod_t'(-limit);
        end
        return mod_t'(shifted);
    endfunction

    // last sample of the voice is folded in before the store
    always_comb begin
        for (int t = 0; t < NUM_OSCS; t++) begin
            acc_next[t] = acc[t] + coef[t][op_in.tag.osc] * op_in.sample;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int t = 0; t < NUM_OSCS; t++) begin
                acc[t] <= '0;
                for (int s = 0; s < NUM_OSCS; s++) begin
                    coef[t][s] <= '0;
                end
            end
            for (int v = 0; v < NUM_VOICES; v++) begin
                for (int t = 0; t < NUM_OSCS; t++) begin
                    mod_store[v][t] <= '0;   // frame 0 is unmodulated
                end
            end
        end else begin
            if (op_in.tag.valid) begin
                for (int t = 0; t < NUM_OSCS; t++) begin
                    if (op_in.tag.last_osc) begin
                        mod_store[op_in.tag.voice][t] <= saturate(acc_next[t]);
                        acc[t] <= '0;
                    end else begin
                        acc[t] <= acc_next[t];
                    end
                end
            end
            if (cfg.we && cfg.kind == CFG_COEF) begin
                coef[cfg.target][cfg.osc] <= coef_t'(cfg.data[7:0]);
            end
        end
    end

    assign mod_value = mod_store[mod_query.voice][mod_query.osc];

endmodule

`default_nettype wire

//--- logic/fm_operator.sv
`default_nettype none

module fm_operator (
    input  wire                        sCLK_XVXENVS,
    input  wire                        reset,
    input  fm_data_pkg::cfg_write_t    cfg,
    input  fm_timing_pkg::slot_tag_t   tag,
    output fm_timing_pkg::slot_tag_t   mod_query,
    input  fm_data_pkg::mod_t          mod_value,
    output fm_data_pkg::op_sample_t    op_out
);

    import fm_timing_pkg::*;
    import fm_data_pkg::*;

    phase_t    phase_mem [NUM_VOICES][NUM_OSCS];
    phase_t    inc_mem   [NUM_VOICES][NUM_OSCS];
    level_t    level_mem [NUM_VOICES][NUM_OSCS];
    sample_t   sine_rom  [256];

    phase_t    mod_offset;                // scaled modulation, wraps mod 2^16
    phase_t    phase_mod;
    slot_tag_t tag_pipe [OP_LATENCY];
    logic [7:0] s1_index;
    level_t    s1_level;
    logic signed [20:0] level_prod;
    sample_t   s2_sample;

    function automatic sample_t sine_entry(int k);
        real angle;
        angle = 2.0 * 3.14159265358979323846 * real'(k) / 256.0;
        return sample_t'(int'(real'(SINE_AMPL) * $sin(angle))); // int cast rounds
    endfunction

    for (genvar k = 0; k < 256; k++) begin : g_sine
        localparam sample_t ENTRY = sine_entry(k);
        assign sine_rom[k] = ENTRY;
    end

    // the matrix answers this in the same cycle
    assign mod_query = tag;

    always_comb begin
        mod_offset = phase_t'(mod_value * MOD_PHASE_SCALE);
        phase_mod  = phase_mem[tag.voice][tag.osc] + mod_offset;
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                for (int o = 0; o < NUM_OSCS; o++) begin
                    phase_mem[v][o] <= '0;
                    inc_mem[v][o]   <= '0;
                    level_mem[v][o] <= '0;
                end
            end
        end else begin
            if (tag.valid) begin
                phase_mem[tag.voice][tag.osc] <= phase_mem[tag.voice][tag.osc]
                                               + inc_mem[tag.voice][tag.osc];
            end
            if (cfg.we && cfg.kind == CFG_INC) begin
                inc_mem[cfg.voice][cfg.osc] <= phase_t'(cfg.data);
            end
            if (cfg.we && cfg.kind == CFG_LEVEL) begin
                level_mem[cfg.voice][cfg.osc] <= cfg.data[7:0];
            end
        end
    end

    // stage 1 index and level, stage 2 table and scaling
    assign level_prod = sine_rom[s1_index] * $signed({1'b0, s1_level});

    always_ff @(posedge sCLK_XVXENVS) begin
        s1_index  <= phase_mod[15:8];
        s1_level  <= level_mem[tag.voice][tag.osc];
        s2_sample <= sample_t'(level_prod >>> 8);
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int i = 0; i < OP_LATENCY; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= tag;
            for (int i = 1; i < OP_LATENCY; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign op_out = '{tag: tag_pipe[OP_LATENCY-1], sample: s2_sample};

endmodule

`default_nettype wire

//--- logic/slot_sequencer.sv
`default_nettype none

module slot_sequencer (
    input  wire                       sCLK_XVXENVS,
    input  wire                       reset,
    input  logic                      enable,
    output fm_timing_pkg::slot_tag_t  tag
);

    import fm_timing_pkg::*;

    logic [$clog2(NUM_SLOTS)-1:0] slot_q; // next slot to issue
    voice_idx_t                   slot_voice;
    osc_idx_t                     slot_osc;

    // voice-major, operator index counts fastest
    assign slot_voice = slot_q[$bits(slot_q)-1 -: $bits(voice_idx_t)];
    assign slot_osc   = slot_q[$bits(osc_idx_t)-1:0];

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            slot_q <= '0;
            tag    <= '0;
        end else if (enable) begin
            tag <= '{valid:       1'b1,
                     voice:       slot_voice,
                     osc:         slot_osc,
                     last_osc:    (slot_osc == osc_idx_t'(NUM_OSCS - 1)),
                     frame_start: (slot_q == '0)};
            if (slot_q == $bits(slot_q)'(NUM_SLOTS - 1)) begin
                slot_q <= '0;        // frame wrap
            end else begin
                slot_q <= slot_q + 1'b1;
            end
        end else begin
            tag.valid <= 1'b0;       // position held
        end
    end

endmodule

`default_nettype wire

//--- logic/fm_data_pkg.sv
`default_nettype none

package fm_data_pkg;

    typedef logic signed [11:0] sample_t;       // operator sample
    typedef logic signed [11:0] mod_t;          // modulation value
    typedef logic        [15:0] phase_t;
    typedef logic        [7:0]  level_t;
    typedef logic signed [7:0]  coef_t;         // matrix weight
    typedef logic signed [13:0] voice_sample_t; // sum of the carriers

    localparam int SINE_AMPL       = 2047; // sine table peak
    localparam int MOD_SHIFT       = 7;    // applied to the weighted sum
    localparam int MOD_PHASE_SCALE = 64;   // phase units per modulation unit

    typedef enum logic [1:0] {
        CFG_INC,
        CFG_LEVEL,
        CFG_CARRIER,
        CFG_COEF
    } cfg_kind_t;

    typedef struct packed {
        logic                   we;
        cfg_kind_t              kind;
        fm_timing_pkg::voice_idx_t voice;
        fm_timing_pkg::osc_idx_t   osc;
        fm_timing_pkg::osc_idx_t   target; // coefficient row
        logic [15:0]            data;
    } cfg_write_t;

    typedef struct packed {
        fm_timing_pkg::slot_tag_t tag;
        sample_t                  sample;
    } op_sample_t;

    typedef struct packed {
        logic                      valid;
        fm_timing_pkg::voice_idx_t voice;
        voice_sample_t             sum;
    } voice_out_t;

endpackage

`default_nettype wire

//--- logic/fm_timing_pkg.sv
`default_nettype none

package fm_timing_pkg;

    localparam int NUM_VOICES = 4;                    // voices per frame
    localparam int NUM_OSCS   = 4;                    // operators per voice
    localparam int NUM_SLOTS  = NUM_VOICES * NUM_OSCS; // slots per frame

    // cycles from a slot tag to its operator sample
    localparam int OP_LATENCY = 2;

    typedef logic [$clog2(NUM_VOICES)-1:0] voice_idx_t;
    typedef logic [$clog2(NUM_OSCS)-1:0]   osc_idx_t;

    // slot currently in the pipeline
    typedef struct packed {
        logic       valid;       // slot processed this cycle
        voice_idx_t voice;
        osc_idx_t   osc;
        logic       last_osc;    // last operator of the voice
        logic       frame_start; // slot 0
    } slot_tag_t;

endpackage

`default_nettype wire
